//--- design/syst_alu.sv
// Lane-wise add wraps modulo 2^DBW; a clear blocks any add in the same cycle
`timescale 1ns/1ps

module syst_alu import syst_pkg::*; (
	input  logic i_clk,
	input  logic i_reset,
	// Vector to accumulate
	input  logic i_in_rdy,
	output logic o_in_ack,
	input  vec_t i_in_data,
	// Read-and-clear from the drain
	input  logic i_clear,
	output vec_t o_acc
);

	vec_t acc_q;
	vec_t sum;

	// Lane sums, carries never cross lanes
	always_comb begin
		for (int l = 0; l < VSIZE; l++) begin
			sum[l] = lane_t'(acc_q[l] + i_in_data[l]);
		end
	end

	// Never stalls except under a clear
	assign o_in_ack = !i_clear;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			acc_q <= '0;
		end else if (i_clear) begin
			// Clear wins over a pending add
			acc_q <= '0;
		end else if (i_in_rdy) begin
			acc_q <= sum;
		end
	end

	assign o_acc = acc_q;

endmodule

//--- design/syst_cmd_ctrl.sv
// Steps win over loads; no step or load is acked while a drain runs; N_NODES must be at least 2
`timescale 1ns/1ps

module syst_cmd_ctrl import syst_pkg::*; #(
	parameter int N_NODES = 4,
	localparam int NIW = (N_NODES > 1) ? $clog2(N_NODES) : 1
) (
	input  logic               i_clk,
	input  logic               i_reset,
	// Load channel from host
	input  logic               i_load_rdy,
	input  logic [NIW-1:0]     i_load_node,
	input  vec_t               i_load_data,
	output logic               o_load_ack,
	// Register write strobes to the nodes
	output logic [N_NODES-1:0] o_wr_en,
	output vec_t               o_wr_data,
	// Step channel from host
	input  logic               i_step_rdy,
	input  step_op_e           i_step_op,
	output logic               o_step_ack,
	// Per-node step handshake
	output logic [N_NODES-1:0] o_step_rdy,
	output syst_type_t         o_type [N_NODES],
	input  logic [N_NODES-1:0] i_node_ack,
	// Drain coordination
	input  logic               i_drain_active,
	output logic               o_busy
);

	// ========================================
	// Step completion
	// ========================================
	// Nodes that already consumed the current step
	logic [N_NODES-1:0] done_q;
	logic               step_go;

	// Step may only run outside a drain
	assign step_go = i_step_rdy && !i_drain_active;
	// Nodes still owed the step see rdy
	assign o_step_rdy = {N_NODES{step_go}} & ~done_q;
	// Complete once every node acked now or earlier
	assign o_step_ack = step_go && (&(done_q | (i_node_ack & o_step_rdy)));
	// A held step keeps the drain from starting
	assign o_busy = i_step_rdy;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			done_q <= '0;
		end else if (o_step_ack) begin
			done_q <= '0;
		end else if (step_go) begin
			done_q <= done_q | (i_node_ack & o_step_rdy);
		end
	end

	// ========================================
	// Routing decode
	// ========================================
	always_comb begin
		for (int k = 0; k < N_NODES; k++) begin
			// LOCAL by default, own register, nothing passed
			o_type[k].src      = SRC_SELF;
			o_type[k].to_right = 1'b0;
			o_type[k].to_left  = 1'b0;
			case (i_step_op)
				OP_BCAST_RIGHT: begin
					// Node 0 sources, the rest take from the left
					if (k != 0) begin
						o_type[k].src = SRC_LEFT;
					end
					o_type[k].to_right = (k != N_NODES - 1);
				end
				OP_BCAST_LEFT: begin
					// Mirror, last node sources
					if (k != N_NODES - 1) begin
						o_type[k].src = SRC_RIGHT;
					end
					o_type[k].to_left = (k != 0);
				end
				default: begin
				end
			endcase
		end
	end

	// ========================================
	// Loads
	// ========================================
	// Same-cycle ack when no step and no drain
	assign o_load_ack = i_load_rdy && !i_step_rdy && !i_drain_active;
	assign o_wr_data  = i_load_data;

	always_comb begin
		for (int k = 0; k < N_NODES; k++) begin
			o_wr_en[k] = o_load_ack && (i_load_node == NIW'(k));
		end
	end

endmodule

//--- design/syst_drain.sv
// Starts only while no step is pending; one idle cycle sits between consecutive results
`timescale 1ns/1ps

module syst_drain import syst_pkg::*; #(
	parameter int N_NODES = 4,
	localparam int NIW = (N_NODES > 1) ? $clog2(N_NODES) : 1
) (
	input  logic               i_clk,
	input  logic               i_reset,
	// Drain start from host
	input  logic               i_drain_rdy,
	output logic               o_drain_ack,
	// Step pending in the controller
	input  logic               i_busy,
	output logic               o_active,
	// Accumulators of all nodes
	input  vec_t               i_acc [N_NODES],
	// Result stream to host
	output logic               o_res_rdy,
	input  logic               i_res_ack,
	output logic [NIW-1:0]     o_res_node,
	output vec_t               o_res_data,
	// Read-clear strobe, one bit per node
	output logic [N_NODES-1:0] o_clear
);

	typedef enum logic [1:0] {IDLE, SEND, NEXT} drain_state_e;

	drain_state_e   state_q;
	logic [NIW-1:0] idx_q;

	// ========================================
	// Outputs
	// ========================================
	always_comb begin
		o_drain_ack = (state_q == IDLE) && i_drain_rdy && !i_busy;
		o_active    = (state_q != IDLE);
		o_res_rdy   = (state_q == SEND);
		o_res_node  = idx_q;
		o_res_data  = i_acc[idx_q];
		o_clear     = '0;
		// Accepted result clears its node on the same edge
		if (state_q == SEND && i_res_ack) begin
			o_clear[idx_q] = 1'b1;
		end
	end

	// ========================================
	// Walk nodes 0 to N_NODES-1
	// ========================================
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state_q <= IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (o_drain_ack) begin
						state_q <= SEND;
						idx_q   <= '0;
					end
				end
				SEND: begin
					if (i_res_ack) begin
						// Last node ends the drain
						state_q <= (idx_q == NIW'(N_NODES - 1)) ? IDLE : NEXT;
					end
				end
				NEXT: begin
					idx_q   <= idx_q + 1'b1;
					state_q <= SEND;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

endmodule

//--- design/syst_node.sv
// One chain node; neighbours see the switch output only while its rdy toward them is high
`timescale 1ns/1ps

module syst_node import syst_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	// Register write from the controller
	input  logic       i_wr_en,
	input  vec_t       i_wr_data,
	// Step handshake and routing
	input  logic       i_step_rdy,
	output logic       o_step_ack,
	input  syst_type_t i_type,
	// Inputs from the neighbours
	input  logic       i_left_rdy,
	output logic       o_left_ack,
	input  vec_t       i_left_data,
	input  logic       i_right_rdy,
	output logic       o_right_ack,
	input  vec_t       i_right_data,
	// Outputs to the neighbours, one data bus for both
	output logic       o_to_right_rdy,
	input  logic       i_to_right_ack,
	output logic       o_to_left_rdy,
	input  logic       i_to_left_ack,
	output vec_t       o_out_data,
	// Accumulator readout
	input  logic       i_clear,
	output vec_t       o_acc
);

	// Vector register
	vec_t vreg_q;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			vreg_q <= '0;
		end else if (i_wr_en) begin
			vreg_q <= i_wr_data;
		end
	end

	// Switch to ALU handshake
	logic alu_rdy;
	logic alu_ack;

	syst_switch u_switch (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_from_rp_rdy (i_step_rdy),
		.o_from_rp_ack (o_step_ack),
		.i_syst_type   (i_type),
		.i_rp_data     (vreg_q),
		.i_src0_rdy    (i_left_rdy),
		.o_src0_ack    (o_left_ack),
		.i_src0_data   (i_left_data),
		.i_src1_rdy    (i_right_rdy),
		.o_src1_ack    (o_right_ack),
		.i_src1_data   (i_right_data),
		.o_dst0_rdy    (o_to_right_rdy),
		.i_dst0_ack    (i_to_right_ack),
		.o_dst1_rdy    (o_to_left_rdy),
		.i_dst1_ack    (i_to_left_ack),
		.o_alu_rdy     (alu_rdy),
		.i_alu_ack     (alu_ack),
		.o_data        (o_out_data)
	);

	// ALU adds the same vector the neighbours see
	syst_alu u_alu (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_in_rdy  (alu_rdy),
		.o_in_ack  (alu_ack),
		.i_in_data (o_out_data),
		.i_clear   (i_clear),
		.o_acc     (o_acc)
	);

endmodule

//--- design/syst_pkg.sv
// Shared lane, vector and routing types; lane width and vector length are fixed here for all nodes
package syst_pkg;

	// ========================================
	// Vector geometry
	// ========================================
	// Lane width in bits
	localparam int DBW = 8;
	// Lanes per vector
	localparam int VSIZE = 4;

	// One unsigned lane, sums wrap at 2^DBW
	typedef logic [DBW-1:0] lane_t;
	// Packed vector, lane 0 sits in the low bits
	typedef lane_t [VSIZE-1:0] vec_t;

	// ========================================
	// Routing
	// ========================================
	// Where a node takes its vector from in a step
	typedef enum logic [1:0] {
		SRC_SELF  = 2'd0,
		SRC_LEFT  = 2'd1,
		SRC_RIGHT = 2'd2
	} src_sel_e;

	// Per-node routing for one step, 4 bits
	typedef struct packed {
		src_sel_e src;
		logic     to_right;
		logic     to_left;
	} syst_type_t;

	// Step operations issued by the host
	typedef enum logic [1:0] {
		OP_LOCAL       = 2'd0,
		OP_BCAST_RIGHT = 2'd1,
		OP_BCAST_LEFT  = 2'd2
	} step_op_e;

endpackage

//--- design/syst_switch.sv
// Source and type must stay stable while rdy is held; acks are combinational through the chain
`timescale 1ns/1ps

module syst_switch import syst_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	// Step from the controller, carries the routing type
	input  logic       i_from_rp_rdy,
	output logic       o_from_rp_ack,
	input  syst_type_t i_syst_type,
	// Own register contents
	input  vec_t       i_rp_data,
	// src0 comes from the left neighbour
	input  logic       i_src0_rdy,
	output logic       o_src0_ack,
	input  vec_t       i_src0_data,
	// src1 comes from the right neighbour
	input  logic       i_src1_rdy,
	output logic       o_src1_ack,
	input  vec_t       i_src1_data,
	// dst0 goes right, dst1 goes left
	output logic       o_dst0_rdy,
	input  logic       i_dst0_ack,
	output logic       o_dst1_rdy,
	input  logic       i_dst1_ack,
	// Accumulator input
	output logic       o_alu_rdy,
	input  logic       i_alu_ack,
	// Selected vector, shared by all destinations
	output vec_t       o_data
);

	// ========================================
	// Source select
	// ========================================
	logic src_rdy;
	logic src_ack;

	always_comb begin
		src_rdy = 1'b0;
		o_data  = i_rp_data;
		case (i_syst_type.src)
			SRC_LEFT: begin
				src_rdy = i_from_rp_rdy && i_src0_rdy;
				o_data  = i_src0_data;
			end
			SRC_RIGHT: begin
				src_rdy = i_from_rp_rdy && i_src1_rdy;
				o_data  = i_src1_data;
			end
			default: begin
				// Own register is always available
				src_rdy = i_from_rp_rdy;
			end
		endcase
	end

	// ========================================
	// Broadcast to three destinations
	// ========================================
	// Bit 0 right, bit 1 left, bit 2 ALU
	logic [2:0] dst_en;
	logic [2:0] dst_ack;
	logic [2:0] pending;
	logic [2:0] sent_q;

	// Disabled destinations count as done
	assign dst_en  = {1'b1, i_syst_type.to_left, i_syst_type.to_right};
	assign dst_ack = {i_alu_ack, i_dst1_ack, i_dst0_ack};
	assign pending = dst_en & ~sent_q;

	assign o_dst0_rdy = src_rdy && pending[0];
	assign o_dst1_rdy = src_rdy && pending[1];
	assign o_alu_rdy  = src_rdy && pending[2];

	// Last outstanding destination completes the source
	assign src_ack = src_rdy && (&(~pending | dst_ack));

	// Ack back only toward the selected source
	assign o_from_rp_ack = src_ack;
	assign o_src0_ack    = src_ack && (i_syst_type.src == SRC_LEFT);
	assign o_src1_ack    = src_ack && (i_syst_type.src == SRC_RIGHT);

	// Remember destinations served while others still stall
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			sent_q <= '0;
		end else if (src_ack) begin
			sent_q <= '0;
		end else if (src_rdy) begin
			sent_q <= sent_q | (pending & dst_ack);
		end
	end

endmodule

//--- design/syst_top.sv
// Linear chain without wrap; host holds each rdy and its data stable until the matching ack
`timescale 1ns/1ps

module syst_top import syst_pkg::*; #(
	parameter int N_NODES = 4,
	localparam int NIW = (N_NODES > 1) ? $clog2(N_NODES) : 1
) (
	input  logic           i_clk,
	input  logic           i_reset,
	// Load channel
	input  logic           i_load_rdy,
	output logic           o_load_ack,
	input  logic [NIW-1:0] i_load_node,
	input  vec_t           i_load_data,
	// Step channel
	input  logic           i_step_rdy,
	output logic           o_step_ack,
	input  step_op_e       i_step_op,
	// Drain channel and result stream
	input  logic           i_drain_rdy,
	output logic           o_drain_ack,
	output logic           o_res_rdy,
	input  logic           i_res_ack,
	output logic [NIW-1:0] o_res_node,
	output vec_t           o_res_data
);

	// ========================================
	// Controller to nodes
	// ========================================
	logic [N_NODES-1:0] wr_en;
	vec_t               wr_data;
	logic [N_NODES-1:0] step_rdy;
	logic [N_NODES-1:0] node_ack;
	syst_type_t         node_type [N_NODES];
	logic               busy;
	logic               drain_active;
	vec_t               node_acc [N_NODES];
	logic [N_NODES-1:0] clear;

	syst_cmd_ctrl #(.N_NODES(N_NODES)) u_cmd (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_load_rdy     (i_load_rdy),
		.i_load_node    (i_load_node),
		.i_load_data    (i_load_data),
		.o_load_ack     (o_load_ack),
		.o_wr_en        (wr_en),
		.o_wr_data      (wr_data),
		.i_step_rdy     (i_step_rdy),
		.i_step_op      (i_step_op),
		.o_step_ack     (o_step_ack),
		.o_step_rdy     (step_rdy),
		.o_type         (node_type),
		.i_node_ack     (node_ack),
		.i_drain_active (drain_active),
		.o_busy         (busy)
	);

	// ========================================
	// Node chain
	// ========================================
	// Node k drives rt_rdy[k+1] and reads rt_rdy[k], ends tied low
	logic [N_NODES:0]   rt_rdy;
	logic [N_NODES:0]   rt_ack;
	// Node k drives lt_rdy[k] and reads lt_rdy[k+1]
	logic [N_NODES:0]   lt_rdy;
	logic [N_NODES:0]   lt_ack;
	// Node k output sits at index k+1, both ends are zero
	vec_t               node_data [N_NODES+2];

	assign rt_rdy[0]          = 1'b0;
	assign rt_ack[N_NODES]    = 1'b0;
	assign lt_rdy[N_NODES]    = 1'b0;
	assign lt_ack[0]          = 1'b0;
	assign node_data[0]       = '0;
	assign node_data[N_NODES+1] = '0;

	for (genvar k = 0; k < N_NODES; k++) begin : g_node
		syst_node u_node (
			.i_clk          (i_clk),
			.i_reset        (i_reset),
			.i_wr_en        (wr_en[k]),
			.i_wr_data      (wr_data),
			.i_step_rdy     (step_rdy[k]),
			.o_step_ack     (node_ack[k]),
			.i_type         (node_type[k]),
			.i_left_rdy     (rt_rdy[k]),
			.o_left_ack     (rt_ack[k]),
			.i_left_data    (node_data[k]),
			.i_right_rdy    (lt_rdy[k+1]),
			.o_right_ack    (lt_ack[k+1]),
			.i_right_data   (node_data[k+2]),
			.o_to_right_rdy (rt_rdy[k+1]),
			.i_to_right_ack (rt_ack[k+1]),
			.o_to_left_rdy  (lt_rdy[k]),
			.i_to_left_ack  (lt_ack[k]),
			.o_out_data     (node_data[k+1]),
			.i_clear        (clear[k]),
			.o_acc          (node_acc[k])
		);
	end

	// ========================================
	// Output side
	// ========================================
	syst_drain #(.N_NODES(N_NODES)) u_drain (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_drain_rdy (i_drain_rdy),
		.o_drain_ack (o_drain_ack),
		.i_busy      (busy),
		.o_active    (drain_active),
		.i_acc       (node_acc),
		.o_res_rdy   (o_res_rdy),
		.i_res_ack   (i_res_ack),
		.o_res_node  (o_res_node),
		.o_res_data  (o_res_data),
		.o_clear     (clear)
	);

endmodule

//--- flist.f
design/syst_pkg.sv
design/syst_alu.sv
design/syst_switch.sv
design/syst_node.sv
design/syst_cmd_ctrl.sv
design/syst_drain.sv
design/syst_top.sv
tb/tb_syst_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_syst_top -f flist.f -o tb_syst_top_sim
./obj_dir/tb_syst_top_sim

//--- tb/tb_syst_top.sv
// Expects N_NODES of 4; one request per channel at a time, results acked about three times in four
`timescale 1ns/1ps

module tb_syst_top import syst_pkg::*; ();

	localparam int N_NODES     = 4;
	localparam int NIW         = 2;
	localparam int CLK_PERIOD  = 10;
	localparam int RAND_OPS    = 24;
	localparam int DRAIN_EVERY = 6;
	// Fixed phases hold 20 host operations
	localparam int PLANNED_OPS = 20 + RAND_OPS + RAND_OPS / DRAIN_EVERY;

	logic           i_clk;
	logic           i_reset;
	logic           i_load_rdy;
	logic [NIW-1:0] i_load_node;
	vec_t           i_load_data;
	logic           i_step_rdy;
	step_op_e       i_step_op;
	logic           i_drain_rdy;
	logic           i_res_ack;
	logic           o_load_ack;
	logic           o_step_ack;
	logic           o_drain_ack;
	logic           o_res_rdy;
	logic [NIW-1:0] o_res_node;
	vec_t           o_res_data;

	// Reference model of registers and accumulators
	vec_t           model_reg [N_NODES];
	vec_t           model_acc [N_NODES];
	// High while the host side knows a drain is running
	logic           drain_window;
	logic [NIW-1:0] exp_res_node;
	vec_t           exp_res_data;
	logic [31:0]    lfsr_q;

	initial i_clk = 1'b0;
	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	syst_top #(.N_NODES(N_NODES)) UUT (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_load_rdy  (i_load_rdy),
		.o_load_ack  (o_load_ack),
		.i_load_node (i_load_node),
		.i_load_data (i_load_data),
		.i_step_rdy  (i_step_rdy),
		.o_step_ack  (o_step_ack),
		.i_step_op   (i_step_op),
		.i_drain_rdy (i_drain_rdy),
		.o_drain_ack (o_drain_ack),
		.o_res_rdy   (o_res_rdy),
		.i_res_ack   (i_res_ack),
		.o_res_node  (o_res_node),
		.o_res_data  (o_res_data)
	);

	// ========================================
	// Failure reporting and random bits
	// ========================================
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("Testbench failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run aborted");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic step_op_e pick_op();
		logic [31:0] b;
		b = take_bits(2);
		case (b[1:0])
			2'd1:    return OP_BCAST_RIGHT;
			2'd2:    return OP_BCAST_LEFT;
			default: return OP_LOCAL;
		endcase
	endfunction

	// ========================================
	// Reference model
	// ========================================
	// Each lane sums in 9 bits, the carry out is dropped
	function automatic vec_t add_lanes(input vec_t a, input vec_t b);
		vec_t     r;
		logic [8:0] t;
		for (int l = 0; l < VSIZE; l++) begin
			t = {1'b0, a[l]} + {1'b0, b[l]};
			r[l] = t[7:0];
		end
		return r;
	endfunction

	task automatic apply_step_model(input step_op_e op);
		vec_t src;
		for (int k = 0; k < N_NODES; k++) begin
			case (op)
				OP_BCAST_RIGHT: src = model_reg[0];
				OP_BCAST_LEFT:  src = model_reg[N_NODES - 1];
				default:        src = model_reg[k];
			endcase
			model_acc[k] = add_lanes(model_acc[k], src);
		end
	endtask

	// ========================================
	// Host channel drivers
	// ========================================
	// All drivers start and end 1 ns after a rising edge, acks are read at the falling edge
	task automatic drive_load(input logic [NIW-1:0] node, input vec_t data);
		i_load_rdy  = 1'b1;
		i_load_node = node;
		i_load_data = data;
		@(negedge i_clk);
		while (!o_load_ack) begin
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#1;
		model_reg[node] = data;
		i_load_rdy = 1'b0;
	endtask

	task automatic do_step(input step_op_e op);
		i_step_rdy = 1'b1;
		i_step_op  = op;
		@(negedge i_clk);
		while (!o_step_ack) begin
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#1;
		apply_step_model(op);
		i_step_rdy = 1'b0;
	endtask

	task automatic do_drain();
		logic accepted;
		exp_res_node = '0;
		exp_res_data = model_acc[0];
		i_drain_rdy  = 1'b1;
		@(negedge i_clk);
		while (!o_drain_ack) begin
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#1;
		i_drain_rdy  = 1'b0;
		drain_window = 1'b1;
		for (int n = 0; n < N_NODES; n++) begin
			accepted = 1'b0;
			while (!accepted) begin
				// Random back-pressure on the result stream
				i_res_ack = (take_bits(2) != 32'd0);
				@(negedge i_clk);
				accepted = o_res_rdy && i_res_ack;
				@(posedge i_clk);
				#1;
			end
			// Reading a result clears that accumulator
			model_acc[n] = '0;
			if (n < N_NODES - 1) begin
				exp_res_node = NIW'(n + 1);
				exp_res_data = model_acc[n + 1];
			end
		end
		i_res_ack    = 1'b0;
		drain_window = 1'b0;
	endtask

	// ========================================
	// Checks
	// ========================================
	a_reset_quiet: assert property (@(posedge i_clk) $fell(i_reset) |->
		!(o_load_ack || o_step_ack || o_drain_ack || o_res_rdy))
		else report_mismatch("o_load_ack/o_step_ack/o_drain_ack/o_res_rdy",
			32'({o_load_ack, o_step_ack, o_drain_ack, o_res_rdy}), 32'd0);

	// Same-cycle acks on an idle unit
	a_load_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_load_rdy && !i_step_rdy && !drain_window) |-> o_load_ack)
		else report_mismatch("o_load_ack", 32'(o_load_ack), 32'd1);
	a_step_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_step_rdy && !drain_window) |-> o_step_ack)
		else report_mismatch("o_step_ack", 32'(o_step_ack), 32'd1);
	a_drain_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_drain_rdy && !i_step_rdy && !drain_window) |-> o_drain_ack)
		else report_mismatch("o_drain_ack", 32'(o_drain_ack), 32'd1);

	// Drain locks out steps and loads
	a_drain_no_step: assert property (@(posedge i_clk) disable iff (i_reset)
		drain_window |-> !o_step_ack)
		else report_mismatch("o_step_ack", 32'(o_step_ack), 32'd0);
	a_drain_no_load: assert property (@(posedge i_clk) disable iff (i_reset)
		drain_window |-> !o_load_ack)
		else report_mismatch("o_load_ack", 32'(o_load_ack), 32'd0);

	// Result stream order, data and hold
	a_res_first: assert property (@(posedge i_clk) disable iff (i_reset)
		$past(o_drain_ack) |-> o_res_rdy)
		else report_mismatch("o_res_rdy", 32'(o_res_rdy), 32'd1);
	a_res_node: assert property (@(posedge i_clk) disable iff (i_reset)
		o_res_rdy |-> (o_res_node == exp_res_node))
		else report_mismatch("o_res_node", 32'(o_res_node), 32'(exp_res_node));
	a_res_data: assert property (@(posedge i_clk) disable iff (i_reset)
		o_res_rdy |-> (o_res_data == exp_res_data))
		else report_mismatch("o_res_data", o_res_data, exp_res_data);
	a_res_hold_rdy: assert property (@(posedge i_clk) disable iff (i_reset)
		$past(o_res_rdy && !i_res_ack) |-> o_res_rdy)
		else report_mismatch("o_res_rdy", 32'(o_res_rdy), 32'd1);
	a_res_hold_data: assert property (@(posedge i_clk) disable iff (i_reset)
		$past(o_res_rdy && !i_res_ack) |-> $stable(o_res_data))
		else report_mismatch("o_res_data", o_res_data, exp_res_data);

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		logic [31:0] pick;
		logic [31:0] node_bits;
		vec_t        data;
		step_op_e    op;
		i_reset      = 1'b1;
		i_load_rdy   = 1'b0;
		i_load_node  = '0;
		i_load_data  = '0;
		i_step_rdy   = 1'b0;
		i_step_op    = OP_LOCAL;
		i_drain_rdy  = 1'b0;
		i_res_ack    = 1'b0;
		drain_window = 1'b0;
		exp_res_node = '0;
		exp_res_data = '0;
		lfsr_q       = 32'h7a98;
		for (int k = 0; k < N_NODES; k++) begin
			model_reg[k] = '0;
			model_acc[k] = '0;
		end
		repeat (3) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		// Idle cycle after reset, no request raised yet
		@(posedge i_clk);
		#1;

		// Fresh unit drains all zeros
		do_drain();

		// Local step returns each loaded vector
		for (int k = 0; k < N_NODES; k++) begin
			drive_load(NIW'(k), take_bits(32));
		end
		do_step(OP_LOCAL);
		do_drain();

		// Both broadcasts with wrapping lanes
		for (int k = 0; k < N_NODES; k++) begin
			drive_load(NIW'(k), take_bits(32));
		end
		do_step(OP_BCAST_RIGHT);
		do_drain();
		do_step(OP_BCAST_LEFT);
		do_drain();

		// Mixed random loads and steps
		for (int i = 0; i < RAND_OPS; i++) begin
			pick = take_bits(1);
			if (pick[0]) begin
				op = pick_op();
				do_step(op);
			end else begin
				node_bits = take_bits(NIW);
				data      = take_bits(32);
				drive_load(node_bits[NIW-1:0], data);
			end
			if ((i % DRAIN_EVERY) == DRAIN_EVERY - 1) begin
				do_drain();
			end
		end

		// Step and load held off by a running drain
		do_step(OP_LOCAL);
		op   = pick_op();
		data = take_bits(32);
		fork
			do_drain();
			begin
				wait (drain_window);
				// Load waits alone for two cycles, then the step joins it
				repeat (2) @(posedge i_clk);
				#1;
				do_step(op);
			end
			begin
				wait (drain_window);
				drive_load(NIW'(1), data);
			end
		join
		do_drain();

		$display("Testbench passed");
		$finish;
	end

	// Watchdog, 20 cycles per planned operation
	initial begin
		repeat (PLANNED_OPS * 20) @(posedge i_clk);
		abort_run("Watchdog expired before all operations completed");
	end

endmodule
